//--- verilog.f
source/vec_decode_pkg.sv
source/inst_queue.sv
source/field_decode.sv
source/op_decode.sv
source/credit_sender.sv
source/vec_decoder_top.sv
verification/tb_clock.sv
verification/vec_decoder_tb.sv

//--- Makefile
TOP := vec_decoder_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/vec_decoder_tb.sv
`timescale 1ns/1ns

module vec_decoder_tb import vec_decode_pkg::*; ();

localparam int IN_DEPTH    = 4;
localparam int OUT_CREDITS = 2;
localparam int NUM_WORDS   = 160;

localparam logic [5:0] VI_CODES [22] = '{
    VADD, VSUB, VRSUB, VMINU, VMIN, VMAXU, VMAX, VAND, VOR, VXOR, VMV,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT, VSLL, VSRL, VSRA
};
localparam logic [5:0] MV_CODES [8] = '{
    VMUL, VMULH, VMULHU, VMULHSU, VMACC, VNMSAC, VMADD, VNMSUB
};

logic      clk;
logic      rst        = 1'b1;
logic      inst_valid = 1'b0;
vec_inst_u inst       = '0;
logic      out_credit = 1'b0;
logic      in_credit;
logic      ctrl_valid;
dec_ctrl_t ctrl;

int        seed          = 32'h9c5e_2e9b;
int        in_avail      = IN_DEPTH;     // upstream credits held
int        out_avail     = OUT_CREDITS;
int        held          = 0;            // delivered with credit not yet returned
int        sent          = 0;
int        got           = 0;
int        credit_pulses = 0;
int        hits [10]     = '{default: 0};
logic      hold_back     = 1'b0;
dec_ctrl_t exp_q [$];

tb_clock #(.PERIOD(4)) clock_gen (.clk(clk));

vec_decoder_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) dut0 (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl)
);

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
endtask

function automatic int rand_below(input int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
endfunction

function automatic logic [31:0] make_word();
    logic [31:0] r;
    logic [31:0] w;
    r = $random(seed);
    w = r;
    case (rand_below(6))
        0: w = {VI_CODES[rand_below(22)], r[25:15],
                (r[1:0] == 2'd0) ? OPIVX : (r[1:0] == 2'd1) ? OPIVI : OPIVV,
                r[11:7], V_ARITH};
        1: w = {MV_CODES[rand_below(8)], r[25:15], r[0] ? OPMVX : OPMVV, r[11:7], V_ARITH};
        2: w = {r[31:20], r[2] ? 5'd0 : r[19:15], CONF, r[3] ? r[11:7] : 5'd0, V_ARITH};
        3: w[6:0] = r[7] ? V_LOAD : V_STORE;
        4: begin
            if (w[6:0] == V_ARITH || w[6:0] == V_LOAD || w[6:0] == V_STORE) begin
                w[0] = ~w[0];                // no longer a vector opcode
            end
        end
        default: w[6:0] = V_ARITH;           // arbitrary funct3/funct6
    endcase
    return w;
endfunction

// expected bundle from the decode rules
function automatic dec_ctrl_t expected_ctrl(input logic [31:0] w);
    dec_ctrl_t  e;
    logic       ok;
    logic [2:0] f3;
    logic [5:0] f6;
    logic [1:0] src;
    logic       rz;
    int         mac_idx;
    e       = '0;
    ok      = 1'b1;
    mac_idx = -1;
    f3      = w[14:12];
    f6      = w[31:26];
    rz      = (w[19:15] == 5'd0) && (w[11:7] != 5'd0);
    src     = (f3 == OPIVX || f3 == OPMVX) ? 2'b01 : (f3 == OPIVI) ? 2'b10 : 2'b00;
    e.cfg.rs1rd_de = 1'b1;
    if (w[6:0] == V_LOAD || w[6:0] == V_STORE) begin
        e.mem.ld_inst         = (w[6:0] == V_LOAD);
        e.mem.st_inst         = (w[6:0] == V_STORE);
        e.exec.vec_reg_wr_en  = 1'b1;
        e.opnd.data_mux1_sel  = 2'b01;
        e.opnd.evlmax_sel     = 1'b1;
        e.mem.stride_sel      = (w[27:26] == 2'b00);
        e.opnd.data_mux2_sel  = !w[26];      // mop 00 and 10
        e.opnd.eew_sel        = !w[26];
        e.mem.index_str       = w[26];       // mop 01 and 11
        e.opnd.offset_vec_en  = w[26];
        e.mem.index_unordered = (w[27:26] == 2'b01);
    end else if (w[6:0] != V_ARITH) begin
        ok = 1'b0;
    end else if (f3 == CONF) begin
        e.cfg.csrwr_en  = 1'b1;
        e.cfg.vl_sel    = w[31] && w[30];
        e.cfg.vtype_sel = !w[31] || w[30];
        if (!(w[31] && w[30])) begin
            e.cfg.rs1rd_de = !rz;
        end
    end else if (f3 == OPIVV || f3 == OPIVX || f3 == OPIVI) begin
        e.exec.vec_reg_wr_en = 1'b1;
        e.opnd.data_mux1_sel = src;
        case (f6)
            VADD: e.exec.unit = EX_ADD;
            VSUB, VRSUB: begin
                e.exec.unit = EX_ADD;
                e.exec.ctrl = 1'b1;
                ok = (f6 == VSUB) ? (f3 != OPIVI) : (f3 != OPIVV);
            end
            VSLL, VSRL, VSRA: begin
                e.exec.unit     = EX_SHIFT;
                e.exec.shift_op = (f6 == VSLL) ? 3'd0 : (f6 == VSRL) ? 3'd1 : 3'd2;
            end
            VAND, VOR, VXOR: begin
                e.exec.unit       = EX_LOGIC;
                e.exec.op_type    = src;
                e.exec.bitwise_op = (f6 == VAND) ? 5'd0 : (f6 == VOR) ? 5'd1 : 5'd2;
            end
            VMINU, VMIN, VMAXU, VMAX: begin
                e.exec.unit       = EX_LOGIC;
                e.exec.op_type    = src;
                e.exec.bitwise_op = (f6 == VMINU) ? 5'd4 : (f6 == VMIN) ? 5'd5 :
                                    (f6 == VMAXU) ? 5'd6 : 5'd7;
                ok = (f3 != OPIVI);
            end
            VMSEQ, VMSNE, VMSLTU, VMSLEU, VMSLT, VMSLE, VMSGT, VMSGTU: begin
                e.exec.unit    = EX_CMP;
                e.exec.op_type = src;
                e.exec.cmp_op  = (f6 == VMSEQ) ? 3'd0 : (f6 == VMSNE) ? 3'd1 :
                                 (f6 == VMSLTU) ? 3'd2 : (f6 == VMSLEU) ? 3'd3 :
                                 (f6 == VMSLT) ? 3'd4 : (f6 == VMSLE) ? 3'd5 :
                                 (f6 == VMSGT) ? 3'd6 : 3'd7;
                if (f6 == VMSLTU || f6 == VMSLT) begin
                    ok = (f3 != OPIVI);
                end
                if (f6 == VMSGTU || f6 == VMSGT) begin
                    ok = (f3 != OPIVV);
                end
            end
            VMV: e.exec.unit = EX_MOVE;
            default: ok = 1'b0;
        endcase
    end else if (f3 == OPMVV || f3 == OPMVX) begin
        e.exec.vec_reg_wr_en = 1'b1;
        e.opnd.data_mux1_sel = src;
        e.exec.signed_mode   = 1'b1;
        case (f6)
            VMUL, VMULH, VMULHSU, VMULHU: begin
                e.exec.unit        = EX_MUL;
                e.exec.mul_low     = (f6 == VMUL);
                e.exec.mul_high    = (f6 != VMUL);
                e.exec.signed_mode = (f6 != VMULHU);
            end
            VMACC:   mac_idx = 0;
            VNMSAC:  mac_idx = 1;
            VMADD:   mac_idx = 2;
            VNMSUB:  mac_idx = 3;
            default: ok = 1'b0;
        endcase
        if (mac_idx >= 0) begin
            e.exec.unit     = EX_MAC;
            e.exec.accum_op = 3'(2 * mac_idx + ((f3 == OPMVX) ? 1 : 0));
            e.exec.ctrl     = (mac_idx % 2 == 1);    // negated forms subtract
        end
    end else begin
        ok = 1'b0;
    end
    if (!ok) begin
        e              = '0;
        e.exec.illegal = 1'b1;
    end
    return e;
endfunction

task automatic note_word(input logic [31:0] w, input dec_ctrl_t e);
    int idx;
    idx = -1;
    if (e.exec.illegal) begin
        idx = 0;
    end else if (e.cfg.csrwr_en) begin
        if (w[31]) begin
            idx = w[30] ? 2 : 3;
        end else if (w[19:15] == 5'd0 && w[11:7] != 5'd0) begin
            idx = 1;
        end
    end else if (e.mem.ld_inst || e.mem.st_inst) begin
        idx = 4 + int'(w[27:26]);
    end else if (w[14:12] == OPMVV || w[14:12] == OPMVX) begin
        idx = 9;
    end else begin
        idx = 8;
    end
    if (idx >= 0) begin
        hits[idx]++;
    end
endtask

function automatic logic all_groups_hit();
    foreach (hits[i]) begin
        if (hits[i] == 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

always @(posedge clk) begin
    if (rst) begin
        out_avail <= OUT_CREDITS;
    end else begin
        out_avail <= out_avail - int'(ctrl_valid) + int'(out_credit);
    end
end

assert property (@(posedge clk) disable iff (rst) ctrl_valid |-> out_avail > 0)
    else stop_with_error($sformatf("Error at %0t: ctrl_valid expected 0 got 1", $time));
assert property (@(posedge clk) disable iff (rst) in_avail <= IN_DEPTH)
    else stop_with_error($sformatf("Error at %0t: in_credit count expected <= %0d got %0d",
                                   $time, IN_DEPTH, in_avail));

always @(negedge clk) begin : drive_and_check
    logic [31:0] w;
    dec_ctrl_t   e;
    if (!rst) begin
        if (in_credit) begin
            in_avail++;
            credit_pulses++;
        end
        if (ctrl_valid) begin
            assert (exp_q.size() > 0)
                else stop_with_error("ctrl_valid fired with no instruction outstanding");
            e = exp_q.pop_front();
            assert (ctrl.exec == e.exec) else stop_with_error($sformatf(
                "Error at %0t: ctrl.exec expected %h got %h", $time, e.exec, ctrl.exec));
            assert (ctrl.opnd == e.opnd) else stop_with_error($sformatf(
                "Error at %0t: ctrl.opnd expected %h got %h", $time, e.opnd, ctrl.opnd));
            assert (ctrl.mem == e.mem) else stop_with_error($sformatf(
                "Error at %0t: ctrl.mem expected %h got %h", $time, e.mem, ctrl.mem));
            assert (ctrl.cfg == e.cfg) else stop_with_error($sformatf(
                "Error at %0t: ctrl.cfg expected %h got %h", $time, e.cfg, ctrl.cfg));
            got++;
            held++;
        end
        inst_valid = 1'b0;
        if (sent < NUM_WORDS && in_avail > 0 && rand_below(4) != 0) begin
            w = make_word();
            e = expected_ctrl(w);
            note_word(w, e);
            exp_q.push_back(e);
            inst       = w;
            inst_valid = 1'b1;
            in_avail--;
            sent++;
        end
        out_credit = 1'b0;
        if (!hold_back && held > 0 && rand_below(3) == 0) begin
            out_credit = 1'b1;                // downstream frees a slot
            held--;
        end
    end
end

initial begin
    int cycles;
    int got_before;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    cycles = 0;
    while (sent < NUM_WORDS / 2) begin
        @(posedge clk);
        cycles++;
        if (cycles > 5000) begin
            stop_with_error("timed out before half of the words were sent");
        end
    end

    hold_back = 1'b1;                         // starve the output side
    cycles = 0;
    while (held < OUT_CREDITS || in_avail > 0) begin
        @(posedge clk);
        cycles++;
        if (cycles > 500) begin
            stop_with_error("pipeline did not back up while credits were held");
        end
    end
    got_before = got;
    repeat (20) @(posedge clk);
    assert (got == got_before)
        else stop_with_error("output continued while no credit was available");
    hold_back = 1'b0;

    cycles = 0;
    while (sent < NUM_WORDS || exp_q.size() > 0) begin
        @(posedge clk);
        cycles++;
        if (cycles > 20000) begin
            stop_with_error("timed out waiting for the pipeline to drain");
        end
    end

    if (credit_pulses != sent || in_avail != IN_DEPTH) begin
        stop_with_error($sformatf("Error at %0t: in_credit pulses expected %0d got %0d",
                                  $time, sent, credit_pulses));
    end else if (!all_groups_hit()) begin
        stop_with_error("stimulus did not reach every instruction group");
    end else begin
        $display("RESULT: PASS");
        $finish;
    end
end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

initial begin
    clk = 1'b0;
    forever begin
        #(PERIOD / 2) clk = ~clk;
    end
end

endmodule

//--- source/vec_decoder_top.sv
`timescale 1ns/1ns

module vec_decoder_top import vec_decode_pkg::*; #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    input  vec_inst_u inst,
    input  logic      out_credit,
    output logic      in_credit,
    output logic      ctrl_valid,
    output dec_ctrl_t ctrl
);

logic      advance;
logic      head_valid;
vec_inst_u head;
logic      field_valid;
fields_t   fields;
logic      op_valid;
dec_ctrl_t op_ctrl;

inst_queue #(
    .IN_DEPTH(IN_DEPTH)
) u_inst_queue (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .advance    (advance),
    .in_credit  (in_credit),
    .head_valid (head_valid),
    .head       (head)
);

field_decode u_field_decode (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .in_valid  (head_valid),
    .inst      (head),
    .out_valid (field_valid),
    .fields    (fields)
);

op_decode u_op_decode (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .in_valid  (field_valid),
    .fields    (fields),
    .out_valid (op_valid),
    .ctrl      (op_ctrl)
);

credit_sender #(
    .OUT_CREDITS(OUT_CREDITS)
) u_credit_sender (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (op_valid),
    .ctrl_in    (op_ctrl),
    .out_credit (out_credit),
    .advance    (advance),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl)
);

endmodule

//--- source/credit_sender.sv
`timescale 1ns/1ns

module credit_sender import vec_decode_pkg::*; #(
    parameter int OUT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  dec_ctrl_t ctrl_in,
    input  logic      out_credit,
    output logic      advance,
    output logic      ctrl_valid,
    output dec_ctrl_t ctrl
);

localparam int CW = $clog2(OUT_CREDITS + 1);

logic          full;
logic [CW-1:0] credits;

assign ctrl_valid = full && (credits != '0);   // send only with a credit
assign advance    = !full || ctrl_valid;

always_ff @(posedge clk) begin
    if (rst) begin
        full    <= 1'b0;
        credits <= CW'(OUT_CREDITS);
    end else begin
        if (advance) begin
            full <= in_valid;
        end
        credits <= credits - CW'(ctrl_valid) + CW'(out_credit);
    end
end

// held while waiting for a credit
always_ff @(posedge clk) begin
    if (advance) begin
        ctrl <= ctrl_in;
    end
end

endmodule

//--- source/op_decode.sv
`timescale 1ns/1ns

module op_decode import vec_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  logic      in_valid,
    input  fields_t   fields,
    output logic      out_valid,
    output dec_ctrl_t ctrl
);

dec_ctrl_t   nxt;
logic        legal;
logic [1:0]  form_sel;
logic        is_mvx;
v_func6_vi_e f6_vi;
v_func6_mv_e f6_mv;

assign f6_vi  = v_func6_vi_e'(fields.funct6);
assign f6_mv  = v_func6_mv_e'(fields.funct6);
assign is_mvx = (fields.funct3 == OPMVX);

// operand 1 source and op_type of logic and compare ops
always_comb begin
    case (fields.funct3)
        OPIVX, OPMVX: form_sel = 2'b01;
        OPIVI:        form_sel = 2'b10;
        default:      form_sel = 2'b00;
    endcase
end

always_comb begin
    nxt              = '0;
    nxt.cfg.rs1rd_de = 1'b1;
    legal            = 1'b0;
    case (fields.cls)
        CLS_ARITH: begin
            nxt.opnd.data_mux1_sel  = form_sel;
            nxt.exec.vec_reg_wr_en  = 1'b1;
            case (fields.funct3)
                OPIVV, OPIVX, OPIVI: begin
                    legal = 1'b1;
                    case (f6_vi)
                        VADD: nxt.exec.unit = EX_ADD;
                        VSUB, VRSUB: begin
                            nxt.exec.unit = EX_ADD;
                            nxt.exec.ctrl = 1'b1;
                            legal = (f6_vi == VSUB) ? (fields.funct3 != OPIVI)
                                                    : (fields.funct3 != OPIVV);
                        end
                        VSLL, VSRL, VSRA: begin
                            nxt.exec.unit     = EX_SHIFT;
                            nxt.exec.shift_op = (f6_vi == VSLL) ? 3'b000 :
                                                (f6_vi == VSRL) ? 3'b001 : 3'b010;
                        end
                        VAND, VOR, VXOR, VMINU, VMIN, VMAXU, VMAX: begin
                            nxt.exec.unit    = EX_LOGIC;
                            nxt.exec.op_type = form_sel;
                            case (f6_vi)
                                VAND:    nxt.exec.bitwise_op = 5'b00000;
                                VOR:     nxt.exec.bitwise_op = 5'b00001;
                                VXOR:    nxt.exec.bitwise_op = 5'b00010;
                                default: nxt.exec.bitwise_op = {2'b00, fields.funct6[2:0]};
                            endcase
                            if (fields.funct6[5:3] == 3'b000 && fields.funct3 == OPIVI) begin
                                legal = 1'b0;            // no min/max immediate form
                            end
                        end
                        VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT: begin
                            nxt.exec.unit    = EX_CMP;
                            nxt.exec.op_type = form_sel;
                            case (f6_vi)
                                VMSEQ:   nxt.exec.cmp_op = 3'b000;
                                VMSNE:   nxt.exec.cmp_op = 3'b001;
                                VMSLTU:  nxt.exec.cmp_op = 3'b010;
                                VMSLEU:  nxt.exec.cmp_op = 3'b011;
                                VMSLT:   nxt.exec.cmp_op = 3'b100;
                                VMSLE:   nxt.exec.cmp_op = 3'b101;
                                VMSGT:   nxt.exec.cmp_op = 3'b110;
                                default: nxt.exec.cmp_op = 3'b111;
                            endcase
                            if ((f6_vi == VMSGTU || f6_vi == VMSGT) && fields.funct3 == OPIVV) begin
                                legal = 1'b0;
                            end
                            if ((f6_vi == VMSLTU || f6_vi == VMSLT) && fields.funct3 == OPIVI) begin
                                legal = 1'b0;
                            end
                        end
                        VMV: nxt.exec.unit = EX_MOVE;
                        default: legal = 1'b0;
                    endcase
                end
                OPMVV, OPMVX: begin
                    legal                = 1'b1;
                    nxt.exec.signed_mode = 1'b1;
                    case (f6_mv)
                        VMUL, VMULH, VMULHSU, VMULHU: begin
                            nxt.exec.unit        = EX_MUL;
                            nxt.exec.mul_low     = (f6_mv == VMUL);
                            nxt.exec.mul_high    = (f6_mv != VMUL);
                            nxt.exec.signed_mode = (f6_mv != VMULHU);
                        end
                        VMACC:  nxt.exec.accum_op = {2'd0, is_mvx};
                        VNMSAC: nxt.exec.accum_op = {2'd1, is_mvx};
                        VMADD:  nxt.exec.accum_op = {2'd2, is_mvx};
                        VNMSUB: nxt.exec.accum_op = {2'd3, is_mvx};
                        default: legal = 1'b0;
                    endcase
                    if (fields.funct6[5:3] == 3'b101) begin
                        nxt.exec.unit = EX_MAC;
                        nxt.exec.ctrl = (f6_mv == VNMSAC) || (f6_mv == VNMSUB);
                    end
                end
                default: legal = 1'b0;   // float and other groups
            endcase
        end
        CLS_CONF: begin
            legal            = 1'b1;
            nxt.cfg.csrwr_en = 1'b1;
            if (!fields.cfg_sel[1]) begin           // vsetvli
                nxt.cfg.vtype_sel = 1'b1;
                nxt.cfg.rs1rd_de  = !fields.rs1z_rdnz;
            end else if (fields.cfg_sel[0]) begin   // vsetivli
                nxt.cfg.vl_sel    = 1'b1;
                nxt.cfg.vtype_sel = 1'b1;
            end else begin                          // vsetvl
                nxt.cfg.rs1rd_de  = !fields.rs1z_rdnz;
            end
        end
        CLS_LOAD, CLS_STORE: begin
            legal                  = 1'b1;
            nxt.mem.ld_inst        = (fields.cls == CLS_LOAD);
            nxt.mem.st_inst        = (fields.cls == CLS_STORE);
            nxt.exec.vec_reg_wr_en = 1'b1;
            nxt.opnd.data_mux1_sel = 2'b01;         // scalar base
            nxt.opnd.evlmax_sel    = 1'b1;
            case (fields.mop)
                2'b00: begin                        // unit stride
                    nxt.mem.stride_sel     = 1'b1;
                    nxt.opnd.data_mux2_sel = 1'b1;
                    nxt.opnd.eew_sel       = 1'b1;
                end
                2'b10: begin                        // constant stride
                    nxt.opnd.data_mux2_sel = 1'b1;
                    nxt.opnd.eew_sel       = 1'b1;
                end
                default: begin                      // indexed
                    nxt.mem.index_str       = 1'b1;
                    nxt.opnd.offset_vec_en  = 1'b1;
                    nxt.mem.index_unordered = (fields.mop == 2'b01);
                end
            endcase
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        nxt              = '0;
        nxt.exec.illegal = 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        out_valid <= 1'b0;
    end else if (advance) begin
        out_valid <= in_valid;
    end
end

always_ff @(posedge clk) begin
    if (advance) begin
        ctrl <= nxt;
    end
end

endmodule

//--- source/field_decode.sv
`timescale 1ns/1ns

module field_decode import vec_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  logic      in_valid,
    input  vec_inst_u inst,
    output logic      out_valid,
    output fields_t   fields
);

fields_t nxt;

always_comb begin
    nxt.funct3  = inst.arith.funct3;
    nxt.funct6  = inst.arith.funct6;
    nxt.mop     = inst.mem.mop;               // memory view of the same word
    nxt.cfg_sel = inst.arith.funct6[5:4];

    // rs1 = x0 with rd != x0 in vsetvli and vsetvl
    nxt.rs1z_rdnz = (inst.arith.vs1 == 5'd0) && (inst.arith.vd != 5'd0);

    case (inst.arith.opcode)
        V_ARITH: begin
            if (inst.arith.funct3 == CONF) begin
                nxt.cls = CLS_CONF;
            end else begin
                nxt.cls = CLS_ARITH;
            end
        end
        V_LOAD: begin
            nxt.cls = CLS_LOAD;
        end
        V_STORE: begin
            nxt.cls = CLS_STORE;
        end
        default: begin
            nxt.cls = CLS_ILLEGAL;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        out_valid <= 1'b0;
    end else if (advance) begin
        out_valid <= in_valid;
    end
end

always_ff @(posedge clk) begin
    if (advance) begin
        fields <= nxt;
    end
end

endmodule

//--- source/inst_queue.sv
`timescale 1ns/1ns

module inst_queue import vec_decode_pkg::*; #(
    parameter int IN_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    input  vec_inst_u inst,
    input  logic      advance,
    output logic      in_credit,
    output logic      head_valid,
    output vec_inst_u head
);

localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
localparam int CW = $clog2(IN_DEPTH + 1);

logic [XLEN-1:0] slots [IN_DEPTH];
logic [PW-1:0]   wr_ptr;
logic [PW-1:0]   rd_ptr;
logic [CW-1:0]   count;
logic            pop;

// wraps at IN_DEPTH for depths that are not powers of two
function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign head_valid = (count != '0);
assign head       = slots[rd_ptr];
assign pop        = advance && head_valid;

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr    <= '0;
        rd_ptr    <= '0;
        count     <= '0;
        in_credit <= 1'b0;
    end else begin
        if (inst_valid) begin
            wr_ptr <= ptr_inc(wr_ptr);   // sender holds a credit
        end
        if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
        count     <= count + CW'(inst_valid) - CW'(pop);
        in_credit <= pop;                // one credit back per pop
    end
end

always_ff @(posedge clk) begin
    if (inst_valid) begin
        slots[wr_ptr] <= inst;
    end
end

endmodule

//--- source/vec_decode_pkg.sv
package vec_decode_pkg;

parameter int XLEN = 32;

typedef enum logic [6:0] {
    V_ARITH = 7'b1010111,
    V_LOAD  = 7'b0000111,
    V_STORE = 7'b0100111
} v_opcode_e;

typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVV = 3'b010,
    OPMVX = 3'b110,
    CONF  = 3'b111
} v_func3_e;

typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMV    = 6'b010111,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
} v_func6_vi_e;

typedef enum logic [5:0] {
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111,
    VMADD   = 6'b101001,
    VNMSUB  = 6'b101011,
    VMACC   = 6'b101101,
    VNMSAC  = 6'b101111
} v_func6_mv_e;

typedef enum logic [2:0] {
    CLS_ARITH,
    CLS_CONF,
    CLS_LOAD,
    CLS_STORE,
    CLS_ILLEGAL
} inst_class_e;

typedef enum logic [2:0] {
    EX_ADD   = 3'b000,
    EX_SHIFT = 3'b001,
    EX_MUL   = 3'b011,
    EX_LOGIC = 3'b100,
    EX_CMP   = 3'b101,
    EX_MOVE  = 3'b110,
    EX_MAC   = 3'b111
} exec_unit_e;

typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    v_func3_e   funct3;
    logic [4:0] vd;
    v_opcode_e  opcode;
} arith_fmt_t;

typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;    // overlaps funct6[1:0]
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;
    v_opcode_e  opcode;
} mem_fmt_t;

typedef union packed {
    arith_fmt_t arith;
    mem_fmt_t   mem;
} vec_inst_u;

typedef struct packed {
    inst_class_e cls;
    v_func3_e    funct3;
    logic [5:0]  funct6;
    logic [1:0]  mop;
    logic [1:0]  cfg_sel;     // inst[31:30]
    logic        rs1z_rdnz;
} fields_t;

typedef struct packed {
    exec_unit_e unit;
    logic [2:0] shift_op;
    logic [4:0] bitwise_op;
    logic [1:0] op_type;
    logic [2:0] cmp_op;
    logic [2:0] accum_op;
    logic       signed_mode;
    logic       mul_low;
    logic       mul_high;
    logic       ctrl;         // subtract
    logic       vec_reg_wr_en;
    logic       illegal;
} exec_ctrl_t;

typedef struct packed {
    logic [1:0] data_mux1_sel;
    logic       data_mux2_sel;
    logic       offset_vec_en;
    logic       eew_sel;      // sew/eew, vlmax/evlmax, emul/vlmul together
    logic       evlmax_sel;
} operand_ctrl_t;

typedef struct packed {
    logic ld_inst;
    logic st_inst;
    logic stride_sel;
    logic index_str;
    logic index_unordered;
} mem_ctrl_t;

typedef struct packed {
    logic csrwr_en;
    logic vl_sel;
    logic vtype_sel;
    logic rs1rd_de;
} cfg_ctrl_t;

typedef struct packed {
    exec_ctrl_t    exec;
    operand_ctrl_t opnd;
    mem_ctrl_t     mem;
    cfg_ctrl_t     cfg;
} dec_ctrl_t;

endpackage
